/* Bender.yml */
package:
  name: afifo

sources:
  - src/afifo_pkg.sv
  - src/gray_sync.sv
  - src/wr_ptr_ctrl.sv
  - src/rd_ptr_ctrl.sv
  - src/fifo_mem.sv
  - src/afifo_top.sv
  - target: test
    files:
      - dv/tb_afifo.sv

/* dv/afifo_golden.txt */
// phase header is tag then count: 0001 order, 0002 full, 0003 streaming, 0000 ends
// after each header come count write words, read back in the same order
0001 0014
1111 2222 3333 4444
5555 6666 7777 8888
9999 aaaa bbbb cccc
dddd eeee ffff 0001
0203 0405 0607 0809
0002 0009
a5a5 5a5a c3c3
3c3c 0f0f f0f0
1234 5678 9abc
0003 0020
0000 ffff 8000 0001
7fff fffe 4000 0002
beef cafe f00d d00d
1357 2468 abcd ef01
0100 0200 0400 0800
1000 2000 4000 8000
fedc ba98 7654 3210
6b6b 9494 2d2d d2d2
0000

/* dv/tb_afifo.sv */
// dual clock fifo testbench
`timescale 1ns/1ps
`default_nettype none

module tb_afifo
	import afifo_pkg::*;
();

	// dut ports
	// clocks start low with no edge at time zero
	logic i_wclk = 1'b0;
	logic gbl_clk = 1'b0;
	logic i_wr_reset_n;
	logic i_rd_reset_n;
	wr_req_t i_wr_req;
	logic i_rd;
	logic o_wr_full;
	rd_resp_t o_rd_resp;

	// raw golden image, then phases split out of it
	logic [15:0] gold [0:67];
	data_t words [$];
	int ph_tag [$];
	int ph_base [$];
	int ph_cnt [$];

	// words accepted by the writer, words consumed by the reader
	int wr_total;
	int rd_total;
	// watchdog
	int cycles;
	int limit;

	afifo_top dut0 (
		.i_wclk (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr_req (i_wr_req),
		.o_wr_full (o_wr_full),
		.gbl_clk (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd (i_rd),
		.o_rd_resp (o_rd_resp)
	);

	// read clock
	initial
	begin
		forever #50 gbl_clk = ~gbl_clk;
	end

	// write clock, unrelated period
	initial
	begin
		forever #35 i_wclk = ~i_wclk;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// head must be valid and hold the expected word
	task automatic check_resp(input rd_resp_t resp, input data_t exp, input string what);
		if (resp.empty !== 1'b0 || resp.data !== exp)
		begin
			$display("MISMATCH at %0t: %s, empty %b data %h, expected %h",
				$time, what, resp.empty, resp.data, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input logic obs, input logic exp, input string what);
		if (obs !== exp)
		begin
			$display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, obs, exp);
			abort_run();
		end
	endtask

	always @(posedge gbl_clk)
	begin
		cycles++;
		if (limit > 0 && cycles >= limit)
		begin
			$display("ERROR at %0t: run hung, still busy after %0d read clock cycles",
				$time, cycles);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// write and read engines
	////////////////////////////////////////////////////////////

	// writes n golden words from base, waits out full
	task automatic write_words(input int base, input int n, input bit gaps,
		input bit watch_full);
		int i;
		int hist [3];
		i = 0;
		for (int k = 0; k < 3; k++)
			hist[k] = rd_total;
		while (i < n)
		begin
			@(negedge i_wclk);
			// reads the write side can know of, two edges old
			hist[2] = hist[1];
			hist[1] = hist[0];
			hist[0] = rd_total;
			if (watch_full && (wr_total - hist[2] < DEPTH - 1))
				check_flag(o_wr_full, 1'b0, "full with room left");
			if (gaps && $urandom_range(3) == 0)
				i_wr_req.wr = 1'b0;
			else if (!o_wr_full)
			begin
				i_wr_req.wr = 1'b1;
				i_wr_req.data = words[base + i];
				i++;
				wr_total++;
			end
			else
				i_wr_req.wr = 1'b0;
		end
		@(negedge i_wclk);
		i_wr_req.wr = 1'b0;
	endtask

	// every valid head is checked, stalled ones too
	task automatic read_words(input int base, input int n, input bit stalls);
		int i;
		i = 0;
		while (i < n)
		begin
			@(negedge gbl_clk);
			if (!o_rd_resp.empty)
			begin
				check_resp(o_rd_resp, words[base + i], "head word");
				if (stalls && $urandom_range(2) == 0)
					i_rd = 1'b0;
				else
				begin
					i_rd = 1'b1;
					i++;
					rd_total++;
				end
			end
			else
				i_rd = 1'b0;
		end
		@(negedge gbl_clk);
		i_rd = 1'b0;
	endtask

	// fill with reader idle, poke while full, then drain
	task automatic fill_and_drain(input int base, input int n);
		int waited;
		// memory plus the head flop, one word more than DEPTH
		if (n != DEPTH + 1)
		begin
			$display("ERROR: full phase holds %0d words, needs %0d", n, DEPTH + 1);
			abort_run();
		end
		write_words(base, n, 1'b0, 1'b0);
		waited = 0;
		while (!o_wr_full && waited < 20)
		begin
			@(negedge i_wclk);
			waited++;
		end
		if (!o_wr_full)
		begin
			$display("ERROR at %0t: o_wr_full did not rise with the fifo filled", $time);
			abort_run();
		end
		// two strobes while full, neither may be stored
		repeat (2)
		begin
			i_wr_req.wr = 1'b1;
			i_wr_req.data = ~words[base];
			@(negedge i_wclk);
			check_flag(o_wr_full, 1'b1, "full after dropped write");
		end
		i_wr_req.wr = 1'b0;
		read_words(base, n, 1'b0);
		repeat (8)
		begin
			@(negedge gbl_clk);
			check_flag(o_rd_resp.empty, 1'b1, "empty after full drain");
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int p;
		int total;
		int base;
		int n;
		i_wr_reset_n = 1'b0;
		i_rd_reset_n = 1'b0;
		i_wr_req = '0;
		i_rd = 1'b0;
		wr_total = 0;
		rd_total = 0;
		cycles = 0;
		limit = 0;
		void'($urandom(32'hc027));

		// header word is the tag, then the count, then the words
		$readmemh("dv/afifo_golden.txt", gold);
		p = 0;
		total = 0;
		while (p < 66 && gold[p] != 16'h0000)
		begin
			ph_tag.push_back(gold[p]);
			ph_cnt.push_back(gold[p + 1]);
			ph_base.push_back(words.size());
			for (int k = 0; k < gold[p + 1]; k++)
				words.push_back(gold[p + 2 + k]);
			total += gold[p + 1];
			p += gold[p + 1] + 2;
		end
		if (words.size() == 0)
		begin
			$display("ERROR: no words found in dv/afifo_golden.txt");
			abort_run();
		end
		limit = 40 * total + 200;

		// reset, flags checked while held and just after
		repeat (16)
		begin
			@(negedge gbl_clk);
			check_flag(o_rd_resp.empty, 1'b1, "empty in reset");
			check_flag(o_wr_full, 1'b0, "full in reset");
		end
		i_rd_reset_n = 1'b1;
		@(negedge i_wclk);
		i_wr_reset_n = 1'b1;
		repeat (4)
		begin
			@(negedge gbl_clk);
			check_flag(o_rd_resp.empty, 1'b1, "empty after reset");
			check_flag(o_wr_full, 1'b0, "full after reset");
		end

		for (int ph = 0; ph < ph_tag.size(); ph++)
		begin
			base = ph_base[ph];
			n = ph_cnt[ph];
			case (ph_tag[ph])
				1:
					fork
						write_words(base, n, 1'b1, 1'b0);
						read_words(base, n, 1'b0);
					join
				2:
					fill_and_drain(base, n);
				3:
					fork
						write_words(base, n, 1'b1, 1'b1);
						read_words(base, n, 1'b1);
					join
				default:
				begin
					$display("ERROR: unknown phase tag %0d in golden file", ph_tag[ph]);
					abort_run();
				end
			endcase
		end

		// everything consumed, reads must find nothing
		@(negedge gbl_clk);
		i_rd = 1'b1;
		repeat (20)
		begin
			@(negedge gbl_clk);
			check_flag(o_rd_resp.empty, 1'b1, "empty at final drain");
		end
		i_rd = 1'b0;
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* src/afifo_pkg.sv */
// async fifo shared types
`default_nettype none

package afifo_pkg;

	////////////////////////////////////////////////////////////
	// sizing
	////////////////////////////////////////////////////////////

	// log2 of the fifo depth
	localparam int LGFIFO = 3;
	// entries in the storage array
	localparam int DEPTH = 1 << LGFIFO;
	// bits per word
	localparam int WIDTH = 16;
	// flops in each synchronizer chain, 2 at least
	localparam int NFF = 2;

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef logic [WIDTH-1:0] data_t;
	typedef logic [LGFIFO-1:0] addr_t;
	// extra msb is the wrap bit, used to tell full from empty
	typedef logic [LGFIFO:0] ptr_t;

	// write side request, one word per strobe
	typedef struct packed {
		logic wr;
		data_t data;
	} wr_req_t;

	// read side response from the registered head stage
	typedef struct packed {
		logic empty;
		data_t data;
	} rd_resp_t;

	// binary to gray, shared by both pointer controllers
	function automatic ptr_t bin2gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

endpackage

`default_nettype wire

/* src/afifo_top.sv */
// dual clock fifo top level
`timescale 1ns/1ps
`default_nettype none

module afifo_top
	import afifo_pkg::*;
(
	// write domain
	input wire logic i_wclk,
	input wire logic i_wr_reset_n,
	input wire wr_req_t i_wr_req,
	output logic o_wr_full,
	// read domain
	input wire logic gbl_clk,
	input wire logic i_rd_reset_n,
	input wire logic i_rd,
	output rd_resp_t o_rd_resp
);

	// memory ports
	logic wr_en;
	addr_t wr_addr;
	addr_t rd_addr;
	data_t rd_data;

	// gray pointers, local and crossed
	ptr_t wgray;
	ptr_t rgray;
	ptr_t wgray_sync;
	ptr_t rgray_sync;

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	// write data goes straight in, enable from the write controller
	fifo_mem u_mem (
		.i_wclk (i_wclk),
		.i_wr_en (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (i_wr_req.data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	////////////////////////////////////////////////////////////
	// pointer control
	////////////////////////////////////////////////////////////

	wr_ptr_ctrl u_wr_ctrl (
		.i_wclk (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr (i_wr_req.wr),
		.i_rgray_sync (rgray_sync),
		.o_wr_full (o_wr_full),
		.o_wr_en (wr_en),
		.o_wr_addr (wr_addr),
		.o_wgray (wgray)
	);

	rd_ptr_ctrl u_rd_ctrl (
		.gbl_clk (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd (i_rd),
		.i_wgray_sync (wgray_sync),
		.i_mem_data (rd_data),
		.o_rd_addr (rd_addr),
		.o_rgray (rgray),
		.o_rd_resp (o_rd_resp)
	);

	// write pointer into the read clock
	gray_sync u_sync_w2r (
		.i_clk (gbl_clk),
		.i_reset_n (i_rd_reset_n),
		.i_gray (wgray),
		.o_gray (wgray_sync)
	);

	// read pointer into the write clock
	gray_sync u_sync_r2w (
		.i_clk (i_wclk),
		.i_reset_n (i_wr_reset_n),
		.i_gray (rgray),
		.o_gray (rgray_sync)
	);

endmodule

`default_nettype wire

/* src/fifo_mem.sv */
// fifo storage array
`timescale 1ns/1ps
`default_nettype none

module fifo_mem
	import afifo_pkg::*;
(
	input wire logic i_wclk,
	input wire logic i_wr_en,
	input wire addr_t i_wr_addr,
	input wire data_t i_wr_data,
	// read port runs off the read domain address
	input wire addr_t i_rd_addr,
	output data_t o_rd_data
);

	// DEPTH words, no reset on the array
	data_t mem [DEPTH];

	// write port, write domain clock
	always_ff @(posedge i_wclk)
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;

	// async read
	// the word at i_rd_addr is stable by the time its pointer crosses
	assign o_rd_data = mem[i_rd_addr];

endmodule

`default_nettype wire

/* src/gray_sync.sv */
// gray pointer synchronizer
`timescale 1ns/1ps
`default_nettype none

module gray_sync
	import afifo_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_reset_n,
	input wire ptr_t i_gray,
	output ptr_t o_gray
);

	// flop chain, stage 0 is the metastable one
	(* ASYNC_REG = "TRUE" *) ptr_t sync_q [NFF];

	always_ff @(posedge i_clk or negedge i_reset_n)
		if (!i_reset_n)
		begin
			for (int i = 0; i < NFF; i++)
				sync_q[i] <= '0;
		end
		else
		begin
			sync_q[0] <= i_gray;
			// shift along the chain
			for (int i = 1; i < NFF; i++)
				sync_q[i] <= sync_q[i-1];
		end

	// last stage is safe to use in this domain
	assign o_gray = sync_q[NFF-1];

endmodule

`default_nettype wire

/* src/rd_ptr_ctrl.sv */
// fifo read pointer and head stage
`timescale 1ns/1ps
`default_nettype none

module rd_ptr_ctrl
	import afifo_pkg::*;
(
	input wire logic gbl_clk,
	input wire logic i_rd_reset_n,
	input wire logic i_rd,
	// write pointer, already in this domain
	input wire ptr_t i_wgray_sync,
	// word at o_rd_addr, combinational from memory
	input wire data_t i_mem_data,
	output addr_t o_rd_addr,
	output ptr_t o_rgray,
	output rd_resp_t o_rd_resp
);

	// rd_bin points at the next word not yet in the head flop
	ptr_t rd_bin;
	ptr_t rgray;
	ptr_t next_rd_bin;

	// memory side empty, before the head stage
	logic mem_empty;
	// head stage wants a new word
	logic rd_load;

	// head stage
	logic head_empty;
	data_t head_data;

	////////////////////////////////////////////////////////////
	// empty detect and load
	////////////////////////////////////////////////////////////

	// empty when both gray pointers agree, wrap bit included
	assign mem_empty = (i_wgray_sync == rgray);

	// refill when the head is free or is being consumed
	assign rd_load = head_empty || i_rd;

	assign next_rd_bin = rd_bin + 1'b1;

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
		if (!i_rd_reset_n)
		begin
			rd_bin <= '0;
			rgray <= '0;
		end
		else if (rd_load && !mem_empty)
		begin
			rd_bin <= next_rd_bin;
			rgray <= bin2gray(next_rd_bin);
		end

	////////////////////////////////////////////////////////////
	// registered head word
	////////////////////////////////////////////////////////////

	// flag comes up empty out of reset
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
		if (!i_rd_reset_n)
			head_empty <= 1'b1;
		else if (rd_load)
			head_empty <= mem_empty;

	// payload, only meaningful while head_empty is low
	always_ff @(posedge gbl_clk)
		if (rd_load)
			head_data <= i_mem_data;

	assign o_rd_resp.empty = head_empty;
	assign o_rd_resp.data = head_data;

	assign o_rd_addr = rd_bin[LGFIFO-1:0];
	assign o_rgray = rgray;

	// held word does not move under back-pressure
	a_head_hold: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(!head_empty && !i_rd) |=> $stable(head_data) && !head_empty);

	// read gray toward the write domain changes one bit at most
	a_rgray_step: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		$onehot0(rgray ^ $past(rgray)));

endmodule

`default_nettype wire

/* src/wr_ptr_ctrl.sv */
// fifo write pointer control
`timescale 1ns/1ps
`default_nettype none

module wr_ptr_ctrl
	import afifo_pkg::*;
(
	input wire logic i_wclk,
	input wire logic i_wr_reset_n,
	input wire logic i_wr,
	// read pointer, already in this domain
	input wire ptr_t i_rgray_sync,
	output logic o_wr_full,
	output logic o_wr_en,
	output addr_t o_wr_addr,
	output ptr_t o_wgray
);

	// binary pointer plus its gray copy
	ptr_t wr_bin;
	ptr_t wgray;
	ptr_t next_wr_bin;

	////////////////////////////////////////////////////////////
	// pointer update
	////////////////////////////////////////////////////////////

	assign next_wr_bin = wr_bin + 1'b1;

	// accepted only when there is room
	assign o_wr_en = i_wr && !o_wr_full;

	// gray is registered next to binary, so it never glitches on the crossing
	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
		if (!i_wr_reset_n)
		begin
			wr_bin <= '0;
			wgray <= '0;
		end
		else if (o_wr_en)
		begin
			wr_bin <= next_wr_bin;
			wgray <= bin2gray(next_wr_bin);
		end

	////////////////////////////////////////////////////////////
	// full flag
	////////////////////////////////////////////////////////////

	// full when read gray is one lap behind
	// in gray form that means the top two bits differ, the rest match
	assign o_wr_full = (i_rgray_sync ==
		{~wgray[LGFIFO:LGFIFO-1], wgray[LGFIFO-2:0]});

	// low bits index the memory, wrap bit dropped
	assign o_wr_addr = wr_bin[LGFIFO-1:0];
	assign o_wgray = wgray;

	// no advance while full, whatever the strobe does
	a_no_adv_full: assert property (@(posedge i_wclk) disable iff (!i_wr_reset_n)
		o_wr_full |=> $stable(wr_bin));

	// gray pointer seen by the read domain moves one bit at a time
	a_wgray_step: assert property (@(posedge i_wclk) disable iff (!i_wr_reset_n)
		$onehot0(wgray ^ $past(wgray)));

endmodule

`default_nettype wire

/* vlog.f */
src/afifo_pkg.sv
src/gray_sync.sv
src/wr_ptr_ctrl.sv
src/rd_ptr_ctrl.sv
src/fifo_mem.sv
src/afifo_top.sv
dv/tb_afifo.sv
